//--- hdl/bank_arbiter.sv
// Narrow always wins and a wide access goes to all banks at once, so steady narrow traffic starves it
`timescale 1ns/100ps
`include "mem_island_settings.svh"

module bank_arbiter (
    input  logic                                            clk_i,
    input  logic                                            rst_i,
    // Narrow requester
    input  logic                                            narrow_req_valid_i,
    input  mem_island_pkg::narrow_req_t                     narrow_req_i,
    // Wide lanes from the splitter
    input  logic                                            wide_pending_i,
    input  mem_island_pkg::bank_req_t [`MI_NUM_BANKS-1:0]   wide_lane_req_i,
    // Bank read data
    input  logic [`MI_NUM_BANKS-1:0][`MI_NARROW_WIDTH-1:0]  bank_rdata_i,
    // Bank requests
    output logic [`MI_NUM_BANKS-1:0]                        bank_valid_o,
    output mem_island_pkg::bank_req_t [`MI_NUM_BANKS-1:0]   bank_req_o,
    // Wide handshake back to the splitter
    output logic                                            wide_grant_o,
    output logic                                            wide_done_o,
    // Narrow response
    output logic                                            narrow_rsp_valid_o,
    output mem_island_pkg::narrow_rsp_t                     narrow_rsp_o
);

    import mem_island_pkg::*;

    // Decoded narrow target
    logic [`MI_BANK_SEL_WIDTH-1:0]  narrow_bank;
    logic [`MI_NUM_BANKS-1:0]       narrow_sel;
    bank_req_t                      narrow_bank_req;

    // Source record for the response cycle
    logic                           narrow_valid_q;
    logic [`MI_BANK_SEL_WIDTH-1:0]  narrow_bank_q;
    logic                           wide_grant_q;

    // --------------------------------------------------
    // Narrow decode
    // --------------------------------------------------
    // Bank from bits [3:2], byte offset dropped
    assign narrow_bank = narrow_req_i.addr[`MI_BANK_LSB +: `MI_BANK_SEL_WIDTH];

    // One-hot target, empty without a strobe
    always_comb begin
        narrow_sel = '0;
        if (narrow_req_valid_i) begin
            narrow_sel[narrow_bank] = 1'b1;
        end
    end

    // Reshape into a bank request, row from bits [11:4]
    always_comb begin
        narrow_bank_req.op    = narrow_req_i.op;
        narrow_bank_req.row   = narrow_req_i.addr[`MI_ROW_LSB +: `MI_ROW_WIDTH];
        narrow_bank_req.wdata = narrow_req_i.wdata;
        narrow_bank_req.be    = narrow_req_i.be;
    end

    // --------------------------------------------------
    // Grant and bank muxing
    // --------------------------------------------------
    // Wide goes only in a cycle with no narrow strobe at all
    // even if the narrow access hits a single bank
    assign wide_grant_o = wide_pending_i & ~narrow_req_valid_i;

    always_comb begin
        for (int k = 0; k < `MI_NUM_BANKS; k++) begin
            bank_valid_o[k] = narrow_sel[k] | wide_grant_o;
            // Narrow owns its bank, otherwise the wide lane
            if (narrow_sel[k]) begin
                bank_req_o[k] = narrow_bank_req;
            end else begin
                bank_req_o[k] = wide_lane_req_i[k];
            end
        end
    end

    // --------------------------------------------------
    // Response routing
    // --------------------------------------------------
    // Remember who was served, matches the bank read latency
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            narrow_valid_q <= 1'b0;
            narrow_bank_q  <= '0;
            wide_grant_q   <= 1'b0;
        end else begin
            narrow_valid_q <= narrow_req_valid_i;
            wide_grant_q   <= wide_grant_o;
            if (narrow_req_valid_i) begin
                narrow_bank_q <= narrow_bank;
            end
        end
    end

    // Responses follow writes too
    assign narrow_rsp_valid_o = narrow_valid_q;
    // Read data of the bank served last cycle
    assign narrow_rsp_o.rdata = bank_rdata_i[narrow_bank_q];
    // All lanes are back one cycle after the grant
    assign wide_done_o        = wide_grant_q;

endmodule

//--- hdl/mem_island_pkg.sv
// Struct layouts follow the settings header and change only together with it
`include "mem_island_settings.svh"

package mem_island_pkg;

    // --------------------------------------------------
    // Enums
    // --------------------------------------------------
    // Access direction, shared by every port
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // Wide request life cycle in the splitter
    typedef enum logic [1:0] {
        WIDE_IDLE   = 2'd0,
        WIDE_WAIT   = 2'd1,
        WIDE_ISSUED = 2'd2
    } wide_state_e;

    // --------------------------------------------------
    // Requests
    // --------------------------------------------------
    // Narrow request, one 32-bit word
    typedef struct packed {
        mem_op_e                        op;
        logic [`MI_ADDR_WIDTH-1:0]      addr;
        logic [`MI_NARROW_WIDTH-1:0]    wdata;
        logic [`MI_NARROW_WIDTH/8-1:0]  be;
    } narrow_req_t;

    // Wide request, one row across all banks
    typedef struct packed {
        mem_op_e                        op;
        logic [`MI_ADDR_WIDTH-1:0]      addr;
        logic [`MI_WIDE_WIDTH-1:0]      wdata;
        logic [`MI_WIDE_WIDTH/8-1:0]    be;
    } wide_req_t;

    // Request as seen by a single bank
    typedef struct packed {
        mem_op_e                        op;
        logic [`MI_ROW_WIDTH-1:0]       row;
        logic [`MI_NARROW_WIDTH-1:0]    wdata;
        logic [`MI_NARROW_WIDTH/8-1:0]  be;
    } bank_req_t;

    // --------------------------------------------------
    // Responses
    // --------------------------------------------------
    // Read data only, valid travels beside it
    typedef struct packed {
        logic [`MI_NARROW_WIDTH-1:0] rdata;
    } narrow_rsp_t;

    typedef struct packed {
        logic [`MI_WIDE_WIDTH-1:0] rdata;
    } wide_rsp_t;

endpackage

//--- hdl/mem_island_settings.svh
// Sizes are fixed and all power of two; only wide accesses aligned to 16 bytes are supported
`ifndef MEM_ISLAND_SETTINGS_SVH
`define MEM_ISLAND_SETTINGS_SVH

// --------------------------------------------------
// Data path sizes
// --------------------------------------------------
// Byte address seen by both requesters
`define MI_ADDR_WIDTH 12
// Narrow port word
`define MI_NARROW_WIDTH 32
// Wide port word, one lane per bank
`define MI_WIDE_WIDTH 128

// --------------------------------------------------
// Bank organisation
// --------------------------------------------------
`define MI_NUM_BANKS 4
// Rows per bank
`define MI_WORDS_PER_BANK 256
// Row index inside a bank
`define MI_ROW_WIDTH 8
// Width of the bank-select field
`define MI_BANK_SEL_WIDTH 2

// --------------------------------------------------
// Address field positions
// --------------------------------------------------
// Bank select sits right above the byte offset
`define MI_BANK_LSB 2
// Row sits above the bank select
`define MI_ROW_LSB 4

`endif

//--- hdl/mem_island_top.sv
// Narrow has strict priority and a wide requester must wait for its response before strobing again
`timescale 1ns/100ps
`include "mem_island_settings.svh"

module mem_island_top (
    input  logic                         clk_i,
    input  logic                         rst_i,
    // Narrow port
    input  logic                         narrow_req_valid_i,
    input  mem_island_pkg::narrow_req_t  narrow_req_i,
    output logic                         narrow_rsp_valid_o,
    output mem_island_pkg::narrow_rsp_t  narrow_rsp_o,
    // Wide port
    input  logic                         wide_req_valid_i,
    input  mem_island_pkg::wide_req_t    wide_req_i,
    output logic                         wide_rsp_valid_o,
    output mem_island_pkg::wide_rsp_t    wide_rsp_o
);

    import mem_island_pkg::*;

    // Splitter to arbiter
    logic                                           wide_pending;
    bank_req_t [`MI_NUM_BANKS-1:0]                  wide_lane_req;
    logic                                           wide_grant;
    logic                                           wide_done;
    // Arbiter to banks and back
    logic [`MI_NUM_BANKS-1:0]                       bank_valid;
    bank_req_t [`MI_NUM_BANKS-1:0]                  bank_req;
    logic [`MI_NUM_BANKS-1:0][`MI_NARROW_WIDTH-1:0] bank_rdata;

    // --------------------------------------------------
    // Arbitration
    // --------------------------------------------------
    bank_arbiter u_arbiter (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .narrow_req_valid_i (narrow_req_valid_i),
        .narrow_req_i       (narrow_req_i),
        .wide_pending_i     (wide_pending),
        .wide_lane_req_i    (wide_lane_req),
        .bank_rdata_i       (bank_rdata),
        .bank_valid_o       (bank_valid),
        .bank_req_o         (bank_req),
        .wide_grant_o       (wide_grant),
        .wide_done_o        (wide_done),
        .narrow_rsp_valid_o (narrow_rsp_valid_o),
        .narrow_rsp_o       (narrow_rsp_o)
    );

    // Wide holding and lane split
    wide_splitter u_splitter (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .wide_req_valid_i (wide_req_valid_i),
        .wide_req_i       (wide_req_i),
        .wide_grant_i     (wide_grant),
        .wide_done_i      (wide_done),
        .bank_rdata_i     (bank_rdata),
        .wide_pending_o   (wide_pending),
        .wide_lane_req_o  (wide_lane_req),
        .wide_rsp_valid_o (wide_rsp_valid_o),
        .wide_rsp_o       (wide_rsp_o)
    );

    // --------------------------------------------------
    // Banks
    // --------------------------------------------------
    for (genvar k = 0; k < `MI_NUM_BANKS; k++) begin : gen_bank
        sram_bank u_bank (
            .clk_i       (clk_i),
            .req_valid_i (bank_valid[k]),
            .req_i       (bank_req[k]),
            .rdata_o     (bank_rdata[k])
        );
    end

endmodule

//--- hdl/sram_bank.sv
// Contents are not reset and rdata_o holds the last read row until the next read
`timescale 1ns/100ps
`include "mem_island_settings.svh"

module sram_bank (
    input  logic                          clk_i,
    input  logic                          req_valid_i,
    input  mem_island_pkg::bank_req_t     req_i,
    output logic [`MI_NARROW_WIDTH-1:0]   rdata_o
);

    import mem_island_pkg::*;

    // Storage array
    logic [`MI_NARROW_WIDTH-1:0] mem_q [`MI_WORDS_PER_BANK];
    // Registered read port
    logic [`MI_NARROW_WIDTH-1:0] rdata_q;

    // --------------------------------------------------
    // Single port access
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            if (req_i.op == OP_WRITE) begin
                // Only enabled bytes are touched
                for (int b = 0; b < `MI_NARROW_WIDTH / 8; b++) begin
                    if (req_i.be[b]) begin
                        mem_q[req_i.row][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                    end
                end
            end else begin
                // Read data shows up next cycle
                rdata_q <= mem_q[req_i.row];
            end
        end
    end

    // Straight from the output register
    assign rdata_o = rdata_q;

endmodule

//--- hdl/wide_splitter.sv
// One wide request in flight and no back-pressure, with address bits [3:0] ignored
`timescale 1ns/100ps
`include "mem_island_settings.svh"

module wide_splitter (
    input  logic                                            clk_i,
    input  logic                                            rst_i,
    // Wide requester
    input  logic                                            wide_req_valid_i,
    input  mem_island_pkg::wide_req_t                       wide_req_i,
    // Arbiter handshake
    input  logic                                            wide_grant_i,
    input  logic                                            wide_done_i,
    input  logic [`MI_NUM_BANKS-1:0][`MI_NARROW_WIDTH-1:0]  bank_rdata_i,
    // Lanes toward the arbiter
    output logic                                            wide_pending_o,
    output mem_island_pkg::bank_req_t [`MI_NUM_BANKS-1:0]   wide_lane_req_o,
    // Wide response
    output logic                                            wide_rsp_valid_o,
    output mem_island_pkg::wide_rsp_t                       wide_rsp_o
);

    import mem_island_pkg::*;

    // Byte enables per lane
    localparam int unsigned LaneBe = `MI_NARROW_WIDTH / 8;

    wide_state_e state_q;
    wide_state_e state_d;
    // Held request while waiting for a free cycle
    wide_req_t   hold_q;
    // Request currently offered to the banks
    wide_req_t   active_req;
    logic        capture;

    // --------------------------------------------------
    // Request FSM
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        capture = 1'b0;
        case (state_q)
            WIDE_IDLE: begin
                if (wide_req_valid_i) begin
                    capture = 1'b1;
                    // Granted right away when no narrow strobe is present
                    if (wide_grant_i) begin
                        state_d = WIDE_ISSUED;
                    end else begin
                        state_d = WIDE_WAIT;
                    end
                end
            end
            WIDE_WAIT: begin
                if (wide_grant_i) begin
                    state_d = WIDE_ISSUED;
                end
            end
            WIDE_ISSUED: begin
                if (wide_done_i) begin
                    // A new strobe may arrive with the response
                    if (wide_req_valid_i) begin
                        capture = 1'b1;
                        state_d = WIDE_WAIT;
                    end else begin
                        state_d = WIDE_IDLE;
                    end
                end
            end
            default: begin
                state_d = WIDE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= WIDE_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Payload only
    always_ff @(posedge clk_i) begin
        if (capture) begin
            hold_q <= wide_req_i;
        end
    end

    // --------------------------------------------------
    // Lane split
    // --------------------------------------------------
    // Fresh strobe bypasses the holding register
    assign active_req     = (state_q == WIDE_WAIT) ? hold_q : wide_req_i;
    assign wide_pending_o = (state_q == WIDE_WAIT) ||
                            ((state_q == WIDE_IDLE) && wide_req_valid_i);

    always_comb begin
        for (int k = 0; k < `MI_NUM_BANKS; k++) begin
            wide_lane_req_o[k].op    = active_req.op;
            // Same row in every bank
            wide_lane_req_o[k].row   = active_req.addr[`MI_ROW_LSB +: `MI_ROW_WIDTH];
            wide_lane_req_o[k].wdata = active_req.wdata[k*`MI_NARROW_WIDTH +: `MI_NARROW_WIDTH];
            wide_lane_req_o[k].be    = active_req.be[k*LaneBe +: LaneBe];
        end
    end

    // --------------------------------------------------
    // Reassembly
    // --------------------------------------------------
    // Lane 0 in the low bits
    always_comb begin
        for (int k = 0; k < `MI_NUM_BANKS; k++) begin
            wide_rsp_o.rdata[k*`MI_NARROW_WIDTH +: `MI_NARROW_WIDTH] = bank_rdata_i[k];
        end
    end

    assign wide_rsp_valid_o = wide_done_i;

endmodule

//--- sim.f
+incdir+hdl
hdl/mem_island_pkg.sv
hdl/sram_bank.sv
hdl/bank_arbiter.sv
hdl/wide_splitter.sv
hdl/mem_island_top.sv
test/mem_island_checker.sv
test/mem_island_assert.sv
test/tb_mem_island.sv

//--- test/mem_island_assert.sv
// Handshake rules only; one wide request may be outstanding, and rules are off during reset
`timescale 1ns/100ps

module mem_island_assert (
    input logic clk_i,
    input logic rst_i,
    input logic narrow_req_valid_i,
    input logic narrow_rsp_valid_o,
    input logic wide_req_valid_i,
    input logic wide_rsp_valid_o
);

    // Wide request strobed and not yet answered
    logic wide_open_q;
    // Count of failed rules
    int   fail_count = 0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wide_open_q <= 1'b0;
        end else if (wide_req_valid_i) begin
            wide_open_q <= 1'b1;
        end else if (wide_rsp_valid_o) begin
            wide_open_q <= 1'b0;
        end
    end

    // Narrow response one cycle after its strobe
    narrow_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        narrow_req_valid_i |=> narrow_rsp_valid_o)
        else begin
            fail_count++;
            $error("narrow response did not follow its strobe");
        end

    // A new wide strobe only once the previous one is answered
    wide_single: assert property (@(posedge clk_i) disable iff (rst_i)
        wide_req_valid_i |-> (!wide_open_q || wide_rsp_valid_o))
        else begin
            fail_count++;
            $error("wide strobe while a wide request is open");
        end

    wide_no_orphan: assert property (@(posedge clk_i) disable iff (rst_i)
        wide_rsp_valid_o |-> wide_open_q)
        else begin
            fail_count++;
            $error("wide response without a wide request");
        end

endmodule

bind mem_island_top mem_island_assert u_assert (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .narrow_req_valid_i (narrow_req_valid_i),
    .narrow_rsp_valid_o (narrow_rsp_valid_o),
    .wide_req_valid_i   (wide_req_valid_i),
    .wide_rsp_valid_o   (wide_rsp_valid_o)
);

//--- test/mem_island_checker.sv
// Byte model in DUT priority order; unwritten bytes are X on both sides and compare equal
`timescale 1ns/100ps
`include "mem_island_settings.svh"

module mem_island_checker (
    input logic                        clk_i,
    input logic                        rst_i,
    input logic                        narrow_req_valid_i,
    input mem_island_pkg::narrow_req_t narrow_req_i,
    input logic                        narrow_rsp_valid_i,
    input mem_island_pkg::narrow_rsp_t narrow_rsp_i,
    input logic                        wide_req_valid_i,
    input mem_island_pkg::wide_req_t   wide_req_i,
    input logic                        wide_rsp_valid_i,
    input mem_island_pkg::wide_rsp_t   wide_rsp_i
);

    import mem_island_pkg::*;

    int mismatch_count = 0;
    int missing_count = 0;

    logic [7:0]   mem_model [1 << `MI_ADDR_WIDTH];
    // Expectations for the coming cycle
    logic         exp_nv = 1'b0;
    logic         exp_nread;
    logic [31:0]  exp_nd;
    logic         exp_wv = 1'b0;
    logic         exp_wread;
    logic [127:0] exp_wd;
    // Wide request held until a narrow-free cycle
    logic         wide_busy = 1'b0;
    wide_req_t    wide_hold;
    logic         in_reset = 1'b0;

    // --------------------------------------------------
    // Model access by byte address
    // --------------------------------------------------
    task automatic access(input int base, input int nbytes, input mem_op_e op,
                          input logic [127:0] wdata, input logic [15:0] be,
                          output logic [127:0] rdata);
        rdata = '0;
        for (int b = 0; b < nbytes; b++) begin
            rdata[b*8 +: 8] = mem_model[base + b];
            if (op == OP_WRITE && be[b]) begin
                mem_model[base + b] = wdata[b*8 +: 8];
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (rst_i) begin
            // First edge sees registers before reset took hold
            if (in_reset && (narrow_rsp_valid_i !== 1'b0 || wide_rsp_valid_i !== 1'b0)) begin
                missing_count++;
                $display("ERROR: response valid high during reset at %0t", $time);
            end
            in_reset = 1'b1;
            exp_nv = 1'b0;
            exp_wv = 1'b0;
            wide_busy = 1'b0;
        end else begin
            // Outputs still hold last cycle's response here
            if (exp_nv !== narrow_rsp_valid_i) begin
                missing_count++;
                $display("ERROR: narrow response valid was %b, expected %b at %0t",
                         narrow_rsp_valid_i, exp_nv, $time);
            end else if (exp_nv && exp_nread && narrow_rsp_i.rdata !== exp_nd) begin
                mismatch_count++;
                $display("MISMATCH narrow_rsp_o.rdata expected %h actual %h",
                         exp_nd, narrow_rsp_i.rdata);
            end
            if (exp_wv !== wide_rsp_valid_i) begin
                missing_count++;
                $display("ERROR: wide response valid was %b, expected %b at %0t",
                         wide_rsp_valid_i, exp_wv, $time);
            end else if (exp_wv && exp_wread && wide_rsp_i.rdata !== exp_wd) begin
                mismatch_count++;
                $display("MISMATCH wide_rsp_o.rdata expected %h actual %h",
                         exp_wd, wide_rsp_i.rdata);
            end
            // Narrow first, it owns the cycle
            exp_nv = narrow_req_valid_i;
            if (narrow_req_valid_i) begin
                exp_nread = (narrow_req_i.op == OP_READ);
                access({narrow_req_i.addr[11:2], 2'b00}, 4, narrow_req_i.op,
                       {96'b0, narrow_req_i.wdata}, {12'b0, narrow_req_i.be}, exp_wd);
                exp_nd = exp_wd[31:0];
            end
            if (wide_req_valid_i && !wide_busy) begin
                wide_busy = 1'b1;
                wide_hold = wide_req_i;
            end
            exp_wv = 1'b0;
            if (wide_busy && !narrow_req_valid_i) begin
                exp_wv = 1'b1;
                exp_wread = (wide_hold.op == OP_READ);
                access({wide_hold.addr[11:4], 4'b0000}, 16, wide_hold.op,
                       wide_hold.wdata, wide_hold.be, exp_wd);
                wide_busy = 1'b0;
            end
        end
    end

endmodule

//--- test/tb_mem_island.sv
// Drives on falling edges; a wide entry waits for its response, narrow entries do not
`timescale 1ns/100ps
`include "mem_island_settings.svh"

module tb_mem_island;

    import mem_island_pkg::*;

    localparam int NUM_ENTRIES = 17;
    localparam int TIMEOUT = 100;
    localparam logic [1:0] PORT_N = 2'd0;
    // Wide alone, or wide with a narrow write in the same cycle
    localparam logic [1:0] PORT_W = 2'd1;
    localparam logic [1:0] PORT_P = 2'd2;

    typedef struct packed {
        logic [1:0]   port;
        mem_op_e      op;
        logic [11:0]  addr;
        logic [127:0] data;
        logic [15:0]  be;
    } stim_t;

    logic clk_i = 1'b0;
    logic rst_i = 1'b1;
    logic narrow_req_valid_i = 1'b0;
    narrow_req_t narrow_req_i = '0;
    logic narrow_rsp_valid_o;
    narrow_rsp_t narrow_rsp_o;
    logic wide_req_valid_i = 1'b0;
    wide_req_t wide_req_i = '0;
    logic wide_rsp_valid_o;
    wide_rsp_t wide_rsp_o;

    stim_t stim_table [NUM_ENTRIES];
    int seed = 32'h825;
    int timeout_count = 0;
    int burst_len;

    always #50 clk_i = ~clk_i;

    mem_island_top DUT (.*);

    mem_island_checker u_checker (
        .clk_i(clk_i), .rst_i(rst_i),
        .narrow_req_valid_i(narrow_req_valid_i), .narrow_req_i(narrow_req_i),
        .narrow_rsp_valid_i(narrow_rsp_valid_o), .narrow_rsp_i(narrow_rsp_o),
        .wide_req_valid_i(wide_req_valid_i), .wide_req_i(wide_req_i),
        .wide_rsp_valid_i(wide_rsp_valid_o), .wide_rsp_i(wide_rsp_o)
    );

    // Poll on falling edges where the response is stable
    task automatic wait_wide_rsp();
        int n;
        n = 0;
        while (wide_rsp_valid_o !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (wide_rsp_valid_o !== 1'b1) begin
            timeout_count++;
            $display("ERROR: no wide response within %0d cycles", TIMEOUT);
        end
    endtask

    task automatic apply_entry(input stim_t s);
        narrow_req_valid_i = (s.port != PORT_W);
        narrow_req_i = '{op: (s.port == PORT_P) ? OP_WRITE : s.op, addr: s.addr,
                         wdata: s.data[31:0], be: s.be[3:0]};
        wide_req_valid_i = (s.port != PORT_N);
        wide_req_i = '{op: (s.port == PORT_P) ? OP_READ : s.op, addr: s.addr,
                       wdata: s.data, be: s.be};
        @(negedge clk_i);
        narrow_req_valid_i = 1'b0;
        wide_req_valid_i = 1'b0;
        if (s.port != PORT_N) begin
            wait_wide_rsp();
            @(negedge clk_i);
        end
    endtask

    initial begin
        // Partial byte enables on one word
        stim_table[0]  = '{PORT_N, OP_WRITE, 12'h010, 128'h11223344, 16'h000f};
        stim_table[1]  = '{PORT_N, OP_WRITE, 12'h010, 128'h0000aa00, 16'h0002};
        stim_table[2]  = '{PORT_N, OP_READ,  12'h010, 128'h0, 16'h0};
        stim_table[3]  = '{PORT_N, OP_WRITE, 12'h014, 128'hdeadbeef, 16'h0009};
        stim_table[4]  = '{PORT_N, OP_READ,  12'h014, 128'h0, 16'h0};
        // Wide round trip, then lanes one by one
        stim_table[5]  = '{PORT_W, OP_WRITE, 12'h100,
                           128'h0f0e0d0c_0b0a0908_07060504_03020100, 16'hffff};
        stim_table[6]  = '{PORT_W, OP_READ,  12'h100, 128'h0, 16'h0};
        stim_table[7]  = '{PORT_N, OP_READ,  12'h100, 128'h0, 16'h0};
        stim_table[8]  = '{PORT_N, OP_READ,  12'h104, 128'h0, 16'h0};
        stim_table[9]  = '{PORT_N, OP_READ,  12'h108, 128'h0, 16'h0};
        stim_table[10] = '{PORT_N, OP_READ,  12'h10c, 128'h0, 16'h0};
        // Four narrow words reassembled by one wide read
        stim_table[11] = '{PORT_N, OP_WRITE, 12'h200, 128'ha0a0a0a0, 16'h000f};
        stim_table[12] = '{PORT_N, OP_WRITE, 12'h204, 128'hb1b1b1b1, 16'h000f};
        stim_table[13] = '{PORT_N, OP_WRITE, 12'h208, 128'hc2c2c2c2, 16'h000f};
        stim_table[14] = '{PORT_N, OP_WRITE, 12'h20c, 128'hd3d3d3d3, 16'h000f};
        stim_table[15] = '{PORT_W, OP_READ,  12'h200, 128'h0, 16'h0};
        // Same-cycle pair, narrow write lands before the wide read
        stim_table[16] = '{PORT_P, OP_READ,  12'h204, 128'h55667788, 16'h000f};

        // Narrow read strobe held in reset, no response may come out
        @(negedge clk_i);
        narrow_req_valid_i = 1'b1;
        repeat (3) @(negedge clk_i);
        rst_i = 1'b0;
        narrow_req_valid_i = 1'b0;
        @(negedge clk_i);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            apply_entry(stim_table[i]);
        end

        // --------------------------------------------------
        // Wide read starved by a random narrow burst
        // --------------------------------------------------
        burst_len = 4 + ($unsigned($random(seed)) % 8);
        wide_req_valid_i = 1'b1;
        wide_req_i = '{op: OP_READ, addr: 12'h200, wdata: '0, be: '0};
        for (int i = 0; i < burst_len; i++) begin
            narrow_req_valid_i = 1'b1;
            narrow_req_i.op = mem_op_e'($random(seed) & 1);
            narrow_req_i.addr = {4'h2, 4'h0, 2'($random(seed)), 2'b00};
            narrow_req_i.wdata = $random(seed);
            narrow_req_i.be = 4'($random(seed));
            @(negedge clk_i);
            wide_req_valid_i = 1'b0;
        end
        narrow_req_valid_i = 1'b0;
        wait_wide_rsp();
        repeat (2) @(negedge clk_i);

        $display("Errors: mismatch %0d, missing or unexpected %0d, timeout %0d, assertion %0d",
                 u_checker.mismatch_count, u_checker.missing_count, timeout_count,
                 DUT.u_assert.fail_count);
        if (u_checker.mismatch_count + u_checker.missing_count + timeout_count
            + DUT.u_assert.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
